// ==== mem_pkg.sv ====
// Shared widths, message structs and helpers for the test memory
// Address is 8 bits; the array itself may be smaller and then aliases
// Length field of 0 encodes a full-width access of BYTES_PER_WORD bytes
// DATA_W must be a power-of-two multiple of 8

package mem_pkg;

  // ------------------------------
  // Message field widths
  // ------------------------------

  // Byte address carried in every request
  localparam int unsigned ADDR_W = 8;

  // Data payload in both directions
  localparam int unsigned DATA_W = 32;

  // Bytes in one data word
  localparam int unsigned BYTES_PER_WORD = DATA_W / 8;

  // Length in bytes, 0 standing for a whole word
  localparam int unsigned LEN_W = 2;

  // ------------------------------
  // Message types
  // ------------------------------

  typedef enum logic [0:0] {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_type_e;

  // Request from a client, 43 bits
  typedef struct packed {
    mem_type_e         msg_type;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    logic [DATA_W-1:0] data;
  } mem_req_t;

  // Response back to a client, 35 bits
  // Type and length are echoed from the request
  typedef struct packed {
    mem_type_e         msg_type;
    logic [LEN_W-1:0]  len;
    logic [DATA_W-1:0] data;
  } mem_resp_t;

  // ------------------------------
  // Helpers
  // ------------------------------

  // Number of bytes an access really touches
  // One extra bit since a whole word does not fit in LEN_W bits
  function automatic logic [LEN_W:0] eff_len(input logic [LEN_W-1:0] len);
    logic [LEN_W:0] n;
    if (len == '0) begin
      n = (LEN_W + 1)'(BYTES_PER_WORD);
    end else begin
      n = {1'b0, len};
    end
    return n;
  endfunction

endpackage

// ==== msg_buffer.sv ====
// One-entry valid/ready register for any message type T
// Refills in the same cycle that the held message leaves
// in_ready_o depends combinationally on out_ready_i

`timescale 1ns/10ps

module msg_buffer #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic reset,

  // Upstream side
  input  logic in_valid_i,
  output logic in_ready_o,
  input  T     in_data_i,

  // Downstream side
  output logic out_valid_o,
  input  logic out_ready_i,
  output T     out_data_o
);

  // Entry occupied
  logic full;

  // Held message, payload only
  T     data_q;

  logic in_fire;
  logic out_fire;

  // Handshakes on both sides
  assign out_fire = full && out_ready_i;
  // Room when empty or when the current entry drains this cycle
  assign in_ready_o = !full || out_ready_i;
  assign in_fire = in_valid_i && in_ready_o;

  // Control state
  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (in_fire) begin
      full <= 1'b1;
    end else if (out_fire) begin
      full <= 1'b0;
    end
  end

  // Payload captured on each accepted message
  always_ff @(posedge clk) begin
    if (in_fire) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = full;
  assign out_data_o  = data_q;

endmodule

// ==== mem_port.sv ====
// One client port of the shared test memory
// Holds at most one pending request and one pending response
// Responses return in request order; latency depends on arbitration
// Only asks for the array when the response can be stored right away

`timescale 1ns/10ps

module mem_port (
  input  logic                          clk,
  input  logic                          reset,

  // Client request
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  input  mem_pkg::mem_req_t             req_i,

  // Client response
  output logic                          resp_valid_o,
  input  logic                          resp_ready_i,
  output mem_pkg::mem_resp_t            resp_o,

  // Arbiter side
  output logic                          access_valid_o,
  output mem_pkg::mem_req_t             access_req_o,
  input  logic                          grant_i,
  input  logic [mem_pkg::DATA_W-1:0]    rd_data_i
);

  import mem_pkg::*;

  // Request buffer output
  logic      held_valid;
  mem_req_t  held_req;

  // Response buffer input
  logic      resp_in_ready;
  mem_resp_t new_resp;

  // ------------------------------
  // Request buffer
  // ------------------------------

  // Drains only when the arbiter grants this port
  msg_buffer #(
    .T (mem_req_t)
  ) req_buf_i (
    .clk         (clk),
    .reset       (reset),
    .in_valid_i  (req_valid_i),
    .in_ready_o  (req_ready_o),
    .in_data_i   (req_i),
    .out_valid_o (held_valid),
    .out_ready_i (grant_i),
    .out_data_o  (held_req)
  );

  // ------------------------------
  // Access request
  // ------------------------------

  // Ask only if the response has somewhere to go
  // so a grant always completes the request in one cycle
  assign access_valid_o = held_valid && resp_in_ready;
  assign access_req_o   = held_req;

  // Response built from the held request and the array read
  // For a write, data is the old contents of the block
  always_comb begin
    new_resp.msg_type = held_req.msg_type;
    new_resp.len      = held_req.len;
    new_resp.data     = rd_data_i;
  end

  // ------------------------------
  // Response buffer
  // ------------------------------

  // Filled at the granting edge
  msg_buffer #(
    .T (mem_resp_t)
  ) resp_buf_i (
    .clk         (clk),
    .reset       (reset),
    .in_valid_i  (grant_i),
    .in_ready_o  (resp_in_ready),
    .in_data_i   (new_resp),
    .out_valid_o (resp_valid_o),
    .out_ready_i (resp_ready_i),
    .out_data_o  (resp_o)
  );

endmodule

// ==== port_arbiter.sv ====
// Round-robin choice of one port per cycle for the single array port
// Grant is combinational from access_valid_i
// Pointer restarts at port 0 after reset

`timescale 1ns/10ps

module port_arbiter #(
  parameter int unsigned NUM_PORTS = 4
) (
  input  logic                                clk,
  input  logic                                reset,

  // Requests from the ports
  input  logic              [NUM_PORTS-1:0]   access_valid_i,
  input  mem_pkg::mem_req_t [NUM_PORTS-1:0]   access_req_i,

  // One-hot grant back to the ports
  output logic              [NUM_PORTS-1:0]   grant_o,

  // Access toward the array
  output logic                                do_access_o,
  output mem_pkg::mem_req_t                   mem_req_o
);

  import mem_pkg::*;

  // Pointer width, at least one bit
  localparam int unsigned PTR_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

  // Port with highest priority this cycle
  logic [PTR_W-1:0] ptr;

  // Winner of the search
  logic [PTR_W-1:0] sel;
  logic             found;

  // ------------------------------
  // Search from the pointer
  // ------------------------------

  always_comb begin
    int idx;
    found = 1'b0;
    sel   = '0;
    for (int i = 0; i < int'(NUM_PORTS); i++) begin
      // Wrap around the port range
      idx = (int'(ptr) + i) % int'(NUM_PORTS);
      if (!found && access_valid_i[idx]) begin
        found = 1'b1;
        sel   = PTR_W'(idx);
      end
    end
  end

  // One-hot grant
  always_comb begin
    grant_o = '0;
    if (found) begin
      grant_o[sel] = 1'b1;
    end
  end

  // Forward the winner to the array
  assign do_access_o = found;
  assign mem_req_o   = access_req_i[sel];

  // Next search starts after the port just served
  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else if (found) begin
      ptr <= (sel == PTR_W'(NUM_PORTS - 1)) ? '0 : sel + 1'b1;
    end
  end

endmodule

// ==== mem_array.sv ====
// Byte-addressed storage with one access per cycle
// Address bits above log2(MEM_BYTES) are ignored, so high addresses alias
// MEM_BYTES must be a power of two and at most 2**ADDR_W
// Contents are not cleared by reset

`timescale 1ns/10ps

module mem_array #(
  parameter int unsigned MEM_BYTES = 256
) (
  input  logic                        clk,

  // Access from the arbiter
  input  logic                        do_access_i,
  input  mem_pkg::mem_req_t           mem_req_i,

  // Shifted block, valid in the same cycle
  output logic [mem_pkg::DATA_W-1:0]  rd_data_o
);

  import mem_pkg::*;

  // ------------------------------
  // Address split
  // ------------------------------

  // Physical byte address width
  localparam int unsigned PHYS_W    = $clog2(MEM_BYTES);
  // Words in the array
  localparam int unsigned NUM_WORDS = MEM_BYTES / BYTES_PER_WORD;
  // Byte offset inside a word
  localparam int unsigned OFF_W     = $clog2(BYTES_PER_WORD);

  logic [PHYS_W-1:0]       phys_addr;
  logic [PHYS_W-OFF_W-1:0] word_idx;
  logic [OFF_W-1:0]        offset;
  logic [LEN_W:0]          len_eff;

  // Storage, one word per entry
  logic [DATA_W-1:0] mem [NUM_WORDS];

  logic [DATA_W-1:0] rd_word;
  logic [DATA_W-1:0] wr_word;
  logic              wr_en;

  // Drop the bits beyond the physical size
  assign phys_addr = mem_req_i.addr[PHYS_W-1:0];
  assign word_idx  = phys_addr[PHYS_W-1:OFF_W];
  assign offset    = phys_addr[OFF_W-1:0];

  // Zero length means a full word
  assign len_eff   = eff_len(mem_req_i.len);

  // ------------------------------
  // Read path
  // ------------------------------

  assign rd_word = mem[word_idx];

  // Shift right by offset bytes, zeros enter from the top
  assign rd_data_o = rd_word >> {offset, 3'b000};

  // ------------------------------
  // Write path
  // ------------------------------

  assign wr_en = do_access_i && (mem_req_i.msg_type == MEM_WRITE);

  // Merge new bytes into the current word
  // byte b of data lands at byte offset+b of the word
  always_comb begin
    wr_word = rd_word;
    for (int b = 0; b < int'(BYTES_PER_WORD); b++) begin
      // Bytes past the end of the word are dropped, never wrapped
      if (b < int'(len_eff) && (int'(offset) + b) < int'(BYTES_PER_WORD)) begin
        wr_word[(int'(offset) + b) * 8 +: 8] = mem_req_i.data[b * 8 +: 8];
      end
    end
  end

  // Write lands at the granting edge
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[word_idx] <= wr_word;
    end
  end

endmodule

// ==== test_mem_top.sv ====
// Shared test memory with NUM_PORTS valid/ready client ports
// Ports share one single-ported array through a round-robin arbiter
// Each port returns responses in its own request order

`timescale 1ns/10ps

module test_mem_top #(
  parameter int unsigned NUM_PORTS = 4,
  parameter int unsigned MEM_BYTES = 256
) (
  input  logic                                 clk,
  input  logic                                 reset,

  // Requests, indexed by port
  input  logic               [NUM_PORTS-1:0]   req_valid_i,
  output logic               [NUM_PORTS-1:0]   req_ready_o,
  input  mem_pkg::mem_req_t  [NUM_PORTS-1:0]   req_i,

  // Responses, indexed by port
  output logic               [NUM_PORTS-1:0]   resp_valid_o,
  input  logic               [NUM_PORTS-1:0]   resp_ready_i,
  output mem_pkg::mem_resp_t [NUM_PORTS-1:0]   resp_o
);

  import mem_pkg::*;

  // Port to arbiter
  logic     [NUM_PORTS-1:0] access_valid;
  mem_req_t [NUM_PORTS-1:0] access_req;
  logic     [NUM_PORTS-1:0] grant;

  // Arbiter to array
  logic              do_access;
  mem_req_t          mem_req;
  // Broadcast to every port, kept only by the granted one
  logic [DATA_W-1:0] rd_data;

  // ------------------------------
  // Client ports
  // ------------------------------

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    mem_port mem_port_i (
      .clk            (clk),
      .reset          (reset),
      .req_valid_i    (req_valid_i[p]),
      .req_ready_o    (req_ready_o[p]),
      .req_i          (req_i[p]),
      .resp_valid_o   (resp_valid_o[p]),
      .resp_ready_i   (resp_ready_i[p]),
      .resp_o         (resp_o[p]),
      .access_valid_o (access_valid[p]),
      .access_req_o   (access_req[p]),
      .grant_i        (grant[p]),
      .rd_data_i      (rd_data)
    );
  end

  // ------------------------------
  // Arbiter and array
  // ------------------------------

  port_arbiter #(
    .NUM_PORTS (NUM_PORTS)
  ) port_arbiter_i (
    .clk            (clk),
    .reset          (reset),
    .access_valid_i (access_valid),
    .access_req_i   (access_req),
    .grant_o        (grant),
    .do_access_o    (do_access),
    .mem_req_o      (mem_req)
  );

  mem_array #(
    .MEM_BYTES (MEM_BYTES)
  ) mem_array_i (
    .clk         (clk),
    .do_access_i (do_access),
    .mem_req_i   (mem_req),
    .rd_data_o   (rd_data)
  );

endmodule

// ==== tb_test_mem.sv ====
// Testbench for the shared test memory
// Responses are checked against a byte-level reference model of the array
// MEM_BYTES is 128 here and the upper half of the address space aliases
// Ports write only inside their own 32-byte range while running in parallel

`timescale 1ns/10ps

module tb_test_mem;

  import mem_pkg::*;

  localparam int NUM_PORTS = 4;
  localparam int MEM_BYTES = 128;
  // About 175 requests in all and none needs more than about 11 cycles
  localparam int MAX_CYCLES = 2000;

  // Expected response and the data bits whose value is known
  typedef struct packed {
    mem_resp_t         resp;
    logic [DATA_W-1:0] care;
  } exp_t;

  logic                      clk;
  logic                      reset;
  logic      [NUM_PORTS-1:0] req_valid_i;
  logic      [NUM_PORTS-1:0] req_ready_o;
  mem_req_t  [NUM_PORTS-1:0] req_i;
  logic      [NUM_PORTS-1:0] resp_valid_o;
  logic      [NUM_PORTS-1:0] resp_ready_i;
  mem_resp_t [NUM_PORTS-1:0] resp_o;

  // Reference model of the array with every byte unknown at start
  logic [7:0] model [MEM_BYTES];
  bit         known [MEM_BYTES];
  exp_t       exp_q [NUM_PORTS][$];

  int seed = 32'h53c1;
  int errors;
  int checks;
  int cycles;
  int test_num;
  int test_errors;
  int done_cnt [NUM_PORTS];
  bit fair_chk;

  test_mem_top #(
    .NUM_PORTS (NUM_PORTS),
    .MEM_BYTES (MEM_BYTES)
  ) test_mem_top_i (
    .clk          (clk),
    .reset        (reset),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_i        (req_i),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_o       (resp_o)
  );

  always #10 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Error: run stopped after %0d cycles with traffic still pending", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ------------------------------
  // Reference model
  // ------------------------------

  // Request accepted at the coming edge
  // Expected data is the block before the write
  task automatic accept(int p);
    mem_req_t r;
    exp_t     e;
    int       a;
    int       off;
    int       n;
    r = req_i[p];
    a = int'(r.addr) % MEM_BYTES;
    off = a % BYTES_PER_WORD;
    a = a - off;
    e.resp.msg_type = r.msg_type;
    e.resp.len = r.len;
    e.resp.data = '0;
    e.care = '1;
    // Shifted read with zero fill above the word end
    for (int b = 0; b + off < BYTES_PER_WORD; b++) begin
      e.resp.data[b*8 +: 8] = model[a + off + b];
      e.care[b*8 +: 8] = {8{known[a + off + b]}};
    end
    if (r.msg_type == MEM_WRITE) begin
      // Length 0 is a whole word
      n = (r.len == '0) ? BYTES_PER_WORD : int'(r.len);
      for (int b = 0; b < n && b + off < BYTES_PER_WORD; b++) begin
        model[a + off + b] = r.data[b*8 +: 8];
        known[a + off + b] = 1'b1;
      end
    end
    exp_q[p].push_back(e);
  endtask

  task automatic check_resp(int p);
    exp_t e;
    checks++;
    if (exp_q[p].size() == 0) begin
      $display("Error: %0t port %0d returned a response with no request pending", $time, p);
      errors++;
    end else begin
      e = exp_q[p].pop_front();
      assert (resp_o[p].msg_type == e.resp.msg_type && resp_o[p].len == e.resp.len &&
              ((resp_o[p].data ^ e.resp.data) & e.care) == '0) else begin
        $display("Error: %0t resp_o[%0d] expected %h actual %h", $time, p, e.resp, resp_o[p]);
        errors++;
      end
      done_cnt[p]++;
    end
  endtask

  // No port may fall more than 2 responses behind another
  task automatic check_fair();
    for (int i = 0; i < NUM_PORTS; i++) begin
      for (int j = 0; j < NUM_PORTS; j++) begin
        assert (done_cnt[i] <= done_cnt[j] + 2) else begin
          $display("Error: %0t port %0d is %0d responses ahead of port %0d", $time, i,
                   done_cnt[i] - done_cnt[j], j);
          errors++;
        end
      end
    end
  endtask

  // Handshakes sampled mid-cycle where all signals are stable
  always @(negedge clk) begin
    if (!reset) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (resp_valid_o[p] && resp_ready_i[p]) check_resp(p);
        if (req_valid_i[p] && req_ready_o[p]) accept(p);
      end
      if (fair_chk) check_fair();
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------

  // Hold one request until the port takes it
  task automatic send(int p, mem_type_e t, logic [7:0] a, logic [1:0] l, logic [31:0] d);
    req_i[p] = '{msg_type: t, addr: a, len: l, data: d};
    req_valid_i[p] = 1'b1;
    do @(negedge clk); while (!req_ready_o[p]);
    @(posedge clk);
    #1;
    req_valid_i[p] = 1'b0;
  endtask

  task automatic full_rw(int p);
    for (int w = 0; w < 8; w++) send(p, MEM_WRITE, 8'(p*32 + w*4), 2'd0, $random(seed));
    for (int w = 0; w < 8; w++) send(p, MEM_READ, 8'(p*32 + w*4), 2'd0, 32'd0);
  endtask

  // Random requests at base plus masked random offset
  task automatic traffic(int p, int count, logic [7:0] base, logic [7:0] mask, bit rd_only);
    mem_type_e t;
    repeat (count) begin
      t = rd_only ? MEM_READ : mem_type_e'(1'($random(seed)));
      send(p, t, base | (8'($random(seed)) & mask), 2'($random(seed)), $random(seed));
    end
  endtask

  // Port 1 holds its response until the other ports finish
  // and then sees random stretches of ready
  task automatic stall_port1();
    while (done_cnt[0] < 6 || done_cnt[2] < 6 || done_cnt[3] < 6) @(negedge clk);
    assert (done_cnt[1] == 0 && req_ready_o[1] == 1'b0) else begin
      $display("Error: %0t port 1 kept accepting while its response was held", $time);
      errors++;
    end
    repeat (20) begin
      @(posedge clk);
      #1;
      resp_ready_i[1] = ~resp_ready_i[1];
      repeat ($random(seed) & 7) @(posedge clk);
    end
    @(posedge clk);
    #1;
    resp_ready_i[1] = 1'b1;
  endtask

  // Wait until every expected response came back
  task automatic drain();
    for (int p = 0; p < NUM_PORTS; p++) begin
      while (exp_q[p].size() != 0) @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic start_test();
    test_errors = errors;
    for (int p = 0; p < NUM_PORTS; p++) done_cnt[p] = 0;
  endtask

  task automatic end_test(string name);
    drain();
    test_num++;
    $display("Test %0d %s: %0d errors", test_num, name, errors - test_errors);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    req_valid_i = '0;
    req_i = '0;
    resp_ready_i = '1;
    errors = 0;
    checks = 0;
    cycles = 0;
    test_num = 0;
    fair_chk = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    start_test();
    @(negedge clk);
    assert (req_ready_o == '1) else begin
      $display("Error: %0t req_ready_o expected %h actual %h", $time, 4'hf, req_ready_o);
      errors++;
    end
    assert (resp_valid_o == '0) else begin
      $display("Error: %0t resp_valid_o expected %h actual %h", $time, 4'h0, resp_valid_o);
      errors++;
    end
    end_test("reset state");

    // Also fills the whole array
    start_test();
    fork
      full_rw(0);
      full_rw(1);
      full_rw(2);
      full_rw(3);
    join
    end_test("full-width writes and reads");

    // Every length and offset inside the port 2 range
    start_test();
    for (int len = 1; len < 4; len++) begin
      for (int off = 0; off < 4; off++) begin
        send(2, MEM_WRITE, 8'(64 + 4*len + off), 2'(len), $random(seed));
      end
    end
    for (int w = 0; w < 8; w++) begin
      for (int off = 0; off < 4; off++) send(2, MEM_READ, 8'(64 + 4*w + off), 2'd0, 32'd0);
    end
    end_test("sub-word access");

    start_test();
    send(0, MEM_WRITE, 8'h10, 2'd0, $random(seed));
    drain();
    send(3, MEM_READ, 8'h10, 2'd0, 32'd0);
    // 0x90 and 0xc6 alias to 0x10 and 0x46
    send(3, MEM_READ, 8'h90, 2'd0, 32'd0);
    send(3, MEM_WRITE, 8'hc6, 2'd2, $random(seed));
    drain();
    send(1, MEM_READ, 8'h44, 2'd0, 32'd0);
    end_test("shared memory across ports");

    start_test();
    resp_ready_i[1] = 1'b0;
    fork
      traffic(1, 12, 8'd32, 8'd31, 1'b0);
      traffic(0, 6, 8'd0, 8'd31, 1'b0);
      traffic(2, 6, 8'd64, 8'd31, 1'b0);
      traffic(3, 6, 8'd96, 8'd31, 1'b0);
      stall_port1();
    join
    end_test("back-pressure");

    // Reads only so any address is safe on every port
    start_test();
    fair_chk = 1'b1;
    fork
      traffic(0, 8, 8'd0, 8'hff, 1'b1);
      traffic(1, 8, 8'd0, 8'hff, 1'b1);
      traffic(2, 8, 8'd0, 8'hff, 1'b1);
      traffic(3, 8, 8'd0, 8'hff, 1'b1);
    join
    end_test("fairness under load");
    fair_chk = 1'b0;

    $display("Responses checked: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
mem_pkg.sv
msg_buffer.sv
mem_port.sv
port_arbiter.sv
mem_array.sv
test_mem_top.sv
tb_test_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_test_mem -f files.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "TESTBENCH PASSED"; then
  exit 0
fi
exit 1
